// ==== hw/qupls_fetch_queue.sv ====
`timescale 1ns/1ps

// Byte queue between the fetch side and the aligner.
// Byte 0 of the array is always the oldest byte, so the aligner sees the
// head instruction at a fixed place. Every edge shifts out the bytes the
// aligner took and appends a new fetch block right after what is left.
// QUEUE_BYTES has to be at least MAX_INS_BYTES + FETCH_BYTES so that a
// full-length instruction can always complete while room is high.
module qupls_fetch_queue #(
	parameter int FETCH_BYTES = 8,
	parameter int QUEUE_BYTES = 32
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  push,
	input  logic [FETCH_BYTES*8-1:0]              push_data,
	input  logic [qupls_pkg::LEN_W-1:0]           pop_len,
	input  logic                                  flush,
	output logic [qupls_pkg::MAX_INS_BYTES*8-1:0] head_window,
	output logic [qupls_pkg::LEN_W-1:0]           head_count,
	output logic                                  room
);
	import qupls_pkg::*;

	// Wide enough to count a completely full queue
	localparam int CNT_W = $clog2(QUEUE_BYTES + 1);

	logic [7:0]       q         [QUEUE_BYTES];
	logic [7:0]       q_nxt     [QUEUE_BYTES];
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] remain;
	logic [CNT_W-1:0] count_nxt;

	// ============================================================
	// Next state of the byte array
	// ============================================================

	always_comb begin
		int src;
		int off;
		// Bytes still queued once the head instruction is gone
		remain = count - CNT_W'(pop_len);
		for (int i = 0; i < QUEUE_BYTES; i++) begin
			src = i + int'(pop_len);
			off = i - int'(remain);
			// Shift toward the head by the popped amount
			q_nxt[i] = (src < QUEUE_BYTES) ? q[src] : 8'h00;
			// The new block lands just behind the surviving bytes,
			// lowest address first
			if (push && off >= 0 && off < FETCH_BYTES) begin
				q_nxt[i] = push_data[off*8 +: 8];
			end
		end
		count_nxt = push ? remain + CNT_W'(FETCH_BYTES) : remain;
	end

	// ============================================================
	// Registers
	// ============================================================

	// A flush empties the queue and drops a fetch and a pop in the same cycle
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			count <= '0;
		end else begin
			count <= count_nxt;
		end
	end

	// Byte contents past count are don't care
	always_ff @(posedge clk) begin
		for (int i = 0; i < QUEUE_BYTES; i++) begin
			q[i] <= q_nxt[i];
		end
	end

	// ============================================================
	// Head view for the aligner
	// ============================================================

	always_comb begin
		for (int b = 0; b < MAX_INS_BYTES; b++) begin
			head_window[b*8 +: 8] = q[b];
		end
	end

	// The aligner never needs to know about more than one whole instruction
	assign head_count = (count > CNT_W'(MAX_INS_BYTES)) ? LEN_W'(MAX_INS_BYTES)
	                                                     : LEN_W'(count);

	// Room for a whole block even if nothing gets popped this cycle
	assign room = (count <= CNT_W'(QUEUE_BYTES - FETCH_BYTES));

	// The fetch side has to honour room, there is no other back-pressure
	a_push_room: assert property (
		@(posedge clk) disable iff (rst)
		push && !flush |-> room
	);

	// The aligner may only take bytes that are actually queued
	a_pop_count: assert property (
		@(posedge clk) disable iff (rst)
		pop_len <= count
	);

endmodule

// ==== hw/qupls_ins_align.sv ====
`timescale 1ns/1ps

// Cuts one whole instruction per cycle out of the head of the byte queue.
// The instruction is taken as soon as all of its bytes are queued and is
// registered out on the same edge that pops its bytes from the queue.
module qupls_ins_align (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic [qupls_pkg::MAX_INS_BYTES*8-1:0] window,
	input  logic [qupls_pkg::LEN_W-1:0]           window_count,
	input  logic [qupls_pkg::LEN_W-1:0]           len,
	input  logic                                  redirect,
	input  logic [qupls_pkg::PC_W-1:0]            redirect_pc,
	output logic [qupls_pkg::LEN_W-1:0]           pop_len,
	output logic                                  ins_valid,
	output logic [qupls_pkg::MAX_INS_BYTES*8-1:0] ins_bytes,
	output logic [qupls_pkg::LEN_W-1:0]           ins_len,
	output logic [qupls_pkg::PC_W-1:0]            ins_pc
);
	import qupls_pkg::*;

	logic            take;
	// Address of the byte now at the head of the queue
	logic [PC_W-1:0] pc;

	// ============================================================
	// Take decision
	// ============================================================

	// The whole instruction must be queued, and a redirect throws the
	// head away instead of issuing it
	assign take = (window_count >= len) && !redirect;

	// Tells the queue how many bytes leave on this edge
	assign pop_len = take ? len : '0;

	// ============================================================
	// Control state
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			ins_valid <= 1'b0;
			pc        <= '0;
		end else begin
			ins_valid <= take;
			if (redirect) begin
				pc <= redirect_pc;
			end else if (take) begin
				pc <= pc + PC_W'(len);
			end
		end
	end

	// ============================================================
	// Output instruction
	// ============================================================

	// Held until the next instruction is taken
	always_ff @(posedge clk) begin
		if (take) begin
			ins_len <= len;
			ins_pc  <= pc;
			// Bytes past the length belong to the next instruction, so blank them
			for (int b = 0; b < MAX_INS_BYTES; b++) begin
				ins_bytes[b*8 +: 8] <= (b < int'(len)) ? window[b*8 +: 8] : 8'h00;
			end
		end
	end

	// An issued instruction always carries a legal length
	a_len_range: assert property (
		@(posedge clk) disable iff (rst)
		ins_valid |-> (ins_len >= LEN_W'(1)) && (ins_len <= LEN_W'(MAX_INS_BYTES))
	);

endmodule

// ==== hw/qupls_ins_length.sv ====
`timescale 1ns/1ps

// Maps the opcode of the head instruction to its length in bytes.
// Purely combinational, so the length is ready in the same cycle as
// the first byte shows up at the head of the queue.
module qupls_ins_length (
	input  qupls_pkg::opcode_t         opcode,
	output logic [qupls_pkg::LEN_W-1:0] len
);
	import qupls_pkg::*;

	// ============================================================
	// Length table
	// ============================================================

	always_comb begin
		casez (opcode)
			// All sixteen branch opcodes share the top nibble 0x2
			7'b010_????:
				len = LEN_W'(5);
			OP_NOP:
				len = LEN_W'(1);
			// Vector ops carry only a short register field
			OP_VEC, OP_VECZ:
				len = LEN_W'(2);
			OP_R1, OP_LDOQ, OP_STOQ, OP_ADDQ:
				len = LEN_W'(3);
			OP_AMO, OP_LDX, OP_STX:
				len = LEN_W'(4);
			OP_CSR:
				len = LEN_W'(5);
			// Floating point has room for an extra operand
			OP_FLT2, OP_FLT3:
				len = LEN_W'(5);
			// Prefixes hold a 32, 64 or 128 bit constant after the opcode byte
			OP_PFXA32, OP_PFXB32, OP_PFXC32:
				len = LEN_W'(5);
			OP_PFXA64, OP_PFXB64, OP_PFXC64:
				len = LEN_W'(9);
			OP_PFXA128, OP_PFXB128, OP_PFXC128:
				len = LEN_W'(17);
			OP_REGS:
				len = LEN_W'(9);
			// OP_ADDI and every opcode not named above are 4 bytes
			default:
				len = LEN_W'(4);
		endcase
	end

endmodule

// ==== hw/qupls_pkg.sv ====
package qupls_pkg;

	// ============================================================
	// Widths shared by the pre-decode front end
	// ============================================================

	// The longest instruction is a 128-bit prefix, 17 bytes
	localparam int MAX_INS_BYTES = 17;
	// Enough bits to hold a length of 0 to 17 bytes
	localparam int LEN_W = 5;
	// Byte address width of the program counter
	localparam int PC_W = 32;

	// ============================================================
	// Opcodes
	// ============================================================

	// The opcode is the low 7 bits of the first byte of an instruction.
	// Sixteen branch opcodes fill 0x20 to 0x2F as one group.
	//
	// Length rule in bytes, applied by qupls_ins_length:
	//   1   OP_NOP
	//   2   OP_VEC, OP_VECZ
	//   3   OP_R1, OP_LDOQ, OP_STOQ, OP_ADDQ
	//   4   OP_AMO, OP_LDX, OP_STX and every opcode not listed here
	//   5   branches, OP_CSR, OP_FLT2, OP_FLT3 and the 32-bit prefixes
	//   9   the 64-bit prefixes and OP_REGS
	//   17  the 128-bit prefixes
	typedef enum logic [6:0] {
		OP_R1      = 7'h01,
		OP_ADDI    = 7'h04,
		OP_CSR     = 7'h07,
		OP_FLT2    = 7'h0C,
		OP_FLT3    = 7'h0D,
		OP_ADDQ    = 7'h0E,
		OP_AMO     = 7'h10,
		OP_LDX     = 7'h18,
		OP_STX     = 7'h19,
		OP_BCC0    = 7'h20,
		OP_BCC1    = 7'h21,
		OP_BCC2    = 7'h22,
		OP_BCC3    = 7'h23,
		OP_BCC4    = 7'h24,
		OP_BCC5    = 7'h25,
		OP_BCC6    = 7'h26,
		OP_BCC7    = 7'h27,
		OP_BCC8    = 7'h28,
		OP_BCC9    = 7'h29,
		OP_BCC10   = 7'h2A,
		OP_BCC11   = 7'h2B,
		OP_BCC12   = 7'h2C,
		OP_BCC13   = 7'h2D,
		OP_BCC14   = 7'h2E,
		OP_BCC15   = 7'h2F,
		OP_LDOQ    = 7'h3A,
		OP_STOQ    = 7'h3B,
		OP_REGS    = 7'h40,
		OP_VEC     = 7'h50,
		OP_VECZ    = 7'h51,
		OP_PFXA32  = 7'h70,
		OP_PFXB32  = 7'h71,
		OP_PFXC32  = 7'h72,
		OP_PFXA64  = 7'h74,
		OP_PFXB64  = 7'h75,
		OP_PFXC64  = 7'h76,
		OP_PFXA128 = 7'h78,
		OP_PFXB128 = 7'h79,
		OP_PFXC128 = 7'h7A,
		OP_NOP     = 7'h7F
	} opcode_t;

endpackage

// ==== hw/qupls_predecode.sv ====
`timescale 1ns/1ps

// Pre-decode front end: byte queue, length decoder and aligner
module qupls_predecode #(
	parameter int FETCH_BYTES = 8,
	parameter int QUEUE_BYTES = 32
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  fetch_valid,
	input  logic [FETCH_BYTES*8-1:0]              fetch_data,
	input  logic                                  redirect,
	input  logic [qupls_pkg::PC_W-1:0]            redirect_pc,
	output logic                                  fetch_room,
	output logic                                  ins_valid,
	output logic [qupls_pkg::MAX_INS_BYTES*8-1:0] ins_bytes,
	output logic [qupls_pkg::LEN_W-1:0]           ins_len,
	output logic [qupls_pkg::PC_W-1:0]            ins_pc
);
	import qupls_pkg::*;

	logic [MAX_INS_BYTES*8-1:0] head_window;
	logic [LEN_W-1:0]           head_count;
	logic [LEN_W-1:0]           len;
	logic [LEN_W-1:0]           pop_len;
	opcode_t                    opcode;

	// ============================================================
	// Byte queue
	// ============================================================

	qupls_fetch_queue #(
		.FETCH_BYTES(FETCH_BYTES),
		.QUEUE_BYTES(QUEUE_BYTES)
	) u_queue (
		.clk        (clk),
		.rst        (rst),
		.push       (fetch_valid),
		.push_data  (fetch_data),
		.pop_len    (pop_len),
		.flush      (redirect),
		.head_window(head_window),
		.head_count (head_count),
		.room       (fetch_room)
	);

	// Opcode sits in the low 7 bits of the first queued byte
	assign opcode = opcode_t'(head_window[6:0]);

	qupls_ins_length u_length (
		.opcode(opcode),
		.len   (len)
	);

	// ============================================================
	// Aligner
	// ============================================================

	qupls_ins_align u_align (
		.clk         (clk),
		.rst         (rst),
		.window      (head_window),
		.window_count(head_count),
		.len         (len),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.pop_len     (pop_len),
		.ins_valid   (ins_valid),
		.ins_bytes   (ins_bytes),
		.ins_len     (ins_len),
		.ins_pc      (ins_pc)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the pre-decode testbench with Verilator and run it.
# The exit status is non-zero when the build fails or the run reports a failure.

TOP=tb_qupls_predecode
OBJ=obj_dir
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module "$TOP" -Mdir "$OBJ" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
if ! grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
	echo "Simulation ended without a result, see $LOG"
	exit 1
fi
exit 0

// ==== sim.f ====
hw/qupls_pkg.sv
hw/qupls_ins_length.sv
hw/qupls_fetch_queue.sv
hw/qupls_ins_align.sv
hw/qupls_predecode.sv
tb/tb_qupls_predecode.sv

// ==== tb/tb_qupls_predecode.sv ====
`timescale 1ns/1ps

module tb_qupls_predecode;
	import qupls_pkg::*;

	localparam int FETCH_BYTES = 8;
	localparam int QUEUE_BYTES = 32;
	localparam int WIN_W = MAX_INS_BYTES * 8;
	// The 300 instruction stream is the longest test at a few hundred cycles,
	// the whole run stays well under a thousand
	localparam int MAX_CYCLES = 4000;
	localparam logic [PC_W-1:0] NEW_PC = 32'h0001_0040;

	logic                     clk = 1'b0;
	logic                     rst;
	logic                     fetch_valid;
	logic [FETCH_BYTES*8-1:0] fetch_data;
	logic                     redirect;
	logic [PC_W-1:0]          redirect_pc;
	logic                     fetch_room;
	logic                     ins_valid;
	logic [WIN_W-1:0]         ins_bytes;
	logic [LEN_W-1:0]         ins_len;
	logic [PC_W-1:0]          ins_pc;

	// Byte stream model and the instructions still expected from the DUT
	logic [7:0]       stream [$];
	int               feed_pos;
	logic [PC_W-1:0]  next_pc = '0;
	logic [WIN_W-1:0] exp_bytes_q [$];
	int               exp_len_q [$];
	logic [PC_W-1:0]  exp_pc_q [$];
	string            cur_test = "reset";

	// Monitor state, occ mirrors the number of bytes held in the queue
	int              cycle = 0;
	int              occ = 0;
	int              push_seen = 0;
	logic            rst_seen = 1'b1;
	logic            redirect_seen = 1'b0;
	int              seen_count;
	int              first_seen_cycle;
	int              last_seen_cycle;
	logic            room_low_seen;

	qupls_predecode #(
		.FETCH_BYTES(FETCH_BYTES),
		.QUEUE_BYTES(QUEUE_BYTES)
	) DUT (
		.clk        (clk),
		.rst        (rst),
		.fetch_valid(fetch_valid),
		.fetch_data (fetch_data),
		.redirect   (redirect),
		.redirect_pc(redirect_pc),
		.fetch_room (fetch_room),
		.ins_valid  (ins_valid),
		.ins_bytes  (ins_bytes),
		.ins_len    (ins_len),
		.ins_pc     (ins_pc)
	);

	always #5 clk = ~clk;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopping at the first error");
	endtask

	// ============================================================
	// Stream model
	// ============================================================

	// Instruction length in bytes from the opcode
	function automatic int ref_len(input logic [6:0] op);
		if (op >= 7'h20 && op <= 7'h2F)
			return 5;
		case (op)
			OP_NOP: return 1;
			OP_VEC, OP_VECZ: return 2;
			OP_R1, OP_LDOQ, OP_STOQ, OP_ADDQ: return 3;
			OP_CSR, OP_FLT2, OP_FLT3, OP_PFXA32, OP_PFXB32, OP_PFXC32: return 5;
			OP_PFXA64, OP_PFXB64, OP_PFXC64, OP_REGS: return 9;
			OP_PFXA128, OP_PFXB128, OP_PFXC128: return 17;
			default: return 4;
		endcase
	endfunction

	// Appends one instruction with random operand bytes and a random bit 7
	task automatic add_ins(input logic [6:0] op);
		int               len;
		logic [WIN_W-1:0] v;
		logic [7:0]       b;
		len = ref_len(op);
		v = '0;
		for (int i = 0; i < len; i++) begin
			b = (i == 0) ? {1'($urandom_range(0, 1)), op} : 8'($urandom());
			v[i*8 +: 8] = b;
			stream.push_back(b);
		end
		exp_bytes_q.push_back(v);
		exp_len_q.push_back(len);
		exp_pc_q.push_back(next_pc);
		next_pc = next_pc + PC_W'(len);
	endtask

	// NOPs fill the last block so every byte fed is a real instruction
	task automatic pad_stream();
		while (stream.size() % FETCH_BYTES != 0)
			add_ins(OP_NOP);
	endtask

	task automatic start_stream(input logic [PC_W-1:0] pc);
		stream.delete();
		feed_pos = 0;
		next_pc = pc;
	endtask

	task automatic clear_stats();
		seen_count = 0;
		first_seen_cycle = 0;
		last_seen_cycle = 0;
		room_low_seen = 1'b0;
	endtask

	function automatic logic [FETCH_BYTES*8-1:0] block_at(input int pos);
		logic [FETCH_BYTES*8-1:0] blk;
		for (int k = 0; k < FETCH_BYTES; k++)
			blk[k*8 +: 8] = stream[pos + k];
		return blk;
	endfunction

	// ============================================================
	// Feeder and drain
	// ============================================================

	// fetch_room seen at a falling edge describes the queue before a block
	// that is already driven, so a block only follows an idle cycle
	task automatic feed_blocks(input int nblocks);
		int sent;
		bit can_push;
		sent = 0;
		while (sent < nblocks && feed_pos < stream.size()) begin
			@(negedge clk);
			can_push = fetch_room && !fetch_valid;
			@(posedge clk);
			if (can_push) begin
				fetch_valid <= 1'b1;
				fetch_data <= block_at(feed_pos);
				feed_pos = feed_pos + FETCH_BYTES;
				sent++;
			end else begin
				fetch_valid <= 1'b0;
			end
		end
		@(posedge clk);
		fetch_valid <= 1'b0;
	endtask

	task automatic wait_drained();
		while (exp_len_q.size() != 0)
			@(posedge clk);
		// Idle cycles catch anything issued past the end of the stream
		repeat (4) @(posedge clk);
	endtask

	// Pads the stream, feeds what is left of it and waits for every instruction
	task automatic run_stream();
		pad_stream();
		feed_blocks(stream.size() / FETCH_BYTES);
		wait_drained();
	endtask

	// ============================================================
	// Monitor and timeout
	// ============================================================

	always @(negedge clk) begin : monitor
		logic [WIN_W-1:0] e_bytes;
		int               e_len;
		logic [PC_W-1:0]  e_pc;
		// Queue level after the last edge, from the push and pop on that edge
		if (rst_seen || redirect_seen)
			occ = 0;
		else
			occ = occ + push_seen - (ins_valid ? int'(ins_len) : 0);
		rst_seen = rst;
		redirect_seen = redirect;
		push_seen = fetch_valid ? FETCH_BYTES : 0;
		if (!rst) begin
			assert (occ <= QUEUE_BYTES) else stop_on_error($sformatf(
				"%s: queue overflow, %0d bytes queued", cur_test, occ));
			assert (fetch_room == (occ <= QUEUE_BYTES - FETCH_BYTES)) else
				stop_on_error($sformatf("MISMATCH %s fetch_room expected %b actual %b",
					cur_test, occ <= QUEUE_BYTES - FETCH_BYTES, fetch_room));
			if (!fetch_room)
				room_low_seen = 1'b1;
		end
		if (!rst && ins_valid) begin
			assert (exp_len_q.size() != 0) else stop_on_error($sformatf(
				"%s: instruction issued at pc %h when none was expected", cur_test, ins_pc));
			if (exp_len_q.size() != 0) begin
				e_bytes = exp_bytes_q.pop_front();
				e_len = exp_len_q.pop_front();
				e_pc = exp_pc_q.pop_front();
				assert (ins_len == LEN_W'(e_len)) else stop_on_error($sformatf(
					"MISMATCH %s ins_len expected %0d actual %0d", cur_test, e_len, ins_len));
				assert (ins_pc == e_pc) else stop_on_error($sformatf(
					"MISMATCH %s ins_pc expected %h actual %h", cur_test, e_pc, ins_pc));
				assert (ins_bytes == e_bytes) else stop_on_error($sformatf(
					"MISMATCH %s ins_bytes expected %h actual %h", cur_test, e_bytes, ins_bytes));
				if (seen_count == 0) begin
					first_seen_cycle = cycle;
				end
				last_seen_cycle = cycle;
				seen_count++;
			end
		end
	end

	always @(posedge clk) begin
		cycle = cycle + 1;
		assert (cycle < MAX_CYCLES) else stop_on_error($sformatf(
			"Timeout: the run reached %0d cycles during %s", cycle, cur_test));
	end

	// ============================================================
	// Tests
	// ============================================================

	task automatic idle_after_reset();
		cur_test = "idle_after_reset";
		repeat (10) begin
			@(negedge clk);
			assert (ins_valid == 1'b0) else stop_on_error($sformatf(
				"MISMATCH %s ins_valid expected 0 actual %b", cur_test, ins_valid));
			assert (fetch_room == 1'b1) else stop_on_error($sformatf(
				"MISMATCH %s fetch_room expected 1 actual %b", cur_test, fetch_room));
		end
	endtask

	// Every length class, all sixteen branches and two opcodes outside the enum
	task automatic length_classes();
		logic [6:0] listed [26];
		cur_test = "length_classes";
		start_stream(next_pc);
		clear_stats();
		listed = '{OP_NOP, OP_VEC, OP_VECZ, OP_R1, OP_LDOQ, OP_STOQ, OP_ADDQ, OP_AMO,
			OP_LDX, OP_STX, OP_ADDI, 7'h05, 7'h63, OP_CSR, OP_FLT2, OP_FLT3,
			OP_PFXA32, OP_PFXB32, OP_PFXC32, OP_PFXA64, OP_PFXB64, OP_PFXC64,
			OP_REGS, OP_PFXA128, OP_PFXB128, OP_PFXC128};
		foreach (listed[i])
			add_ins(listed[i]);
		for (int op = 32; op < 48; op++)
			add_ins(7'(op));
		run_stream();
	endtask

	task automatic straddling_prefixes();
		cur_test = "straddling_prefixes";
		start_stream(next_pc);
		clear_stats();
		add_ins(OP_R1);
		add_ins(OP_PFXA128);
		add_ins(OP_PFXB128);
		add_ins(OP_PFXC128);
		pad_stream();
		// The first prefix spans bytes 3 to 19 and ends in the third block
		feed_blocks(2);
		repeat (8) @(posedge clk);
		assert (seen_count == 1) else stop_on_error($sformatf(
			"MISMATCH %s issued before third block expected 1 actual %0d",
			cur_test, seen_count));
		// The second prefix still waits for bytes from the fifth block
		feed_blocks(1);
		repeat (8) @(posedge clk);
		assert (seen_count == 2) else stop_on_error($sformatf(
			"MISMATCH %s issued after third block expected 2 actual %0d",
			cur_test, seen_count));
		run_stream();
	endtask

	// Many NOPs keep the queue filling faster than it drains
	task automatic random_stream();
		cur_test = "random_stream";
		start_stream(next_pc);
		clear_stats();
		for (int i = 0; i < 300; i++) begin
			if ($urandom_range(0, 99) < 45)
				add_ins(OP_NOP);
			else
				add_ins(7'($urandom_range(0, 127)));
		end
		run_stream();
		assert (room_low_seen) else stop_on_error($sformatf(
			"%s: the queue never filled far enough to drop fetch_room", cur_test));
	endtask

	task automatic redirect_mid_stream();
		cur_test = "redirect_mid_stream";
		start_stream(next_pc);
		clear_stats();
		for (int i = 0; i < 40; i++)
			add_ins(7'($urandom_range(0, 127)));
		pad_stream();
		feed_blocks(3);
		repeat (2) @(posedge clk);
		redirect <= 1'b1;
		redirect_pc <= NEW_PC;
		@(posedge clk);
		redirect <= 1'b0;
		// Whatever was queued when the redirect hit is gone
		exp_bytes_q.delete();
		exp_len_q.delete();
		exp_pc_q.delete();
		start_stream(NEW_PC);
		clear_stats();
		for (int i = 0; i < 20; i++)
			add_ins(7'($urandom_range(0, 127)));
		run_stream();
	endtask

	task automatic nop_back_to_back();
		cur_test = "nop_back_to_back";
		start_stream(next_pc);
		clear_stats();
		repeat (48) add_ins(OP_NOP);
		run_stream();
		assert (last_seen_cycle - first_seen_cycle + 1 == 48) else stop_on_error($sformatf(
			"MISMATCH %s cycles for 48 NOPs expected 48 actual %0d",
			cur_test, last_seen_cycle - first_seen_cycle + 1));
	endtask

	initial begin
		int seed_ret;
		seed_ret = $urandom(1430);
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_data = '0;
		redirect = 1'b0;
		redirect_pc = '0;
		clear_stats();
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		idle_after_reset();
		length_classes();
		straddling_prefixes();
		random_stream();
		redirect_mid_stream();
		nop_back_to_back();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
